// ==== filelist.f ====
sdram_pkg.sv
sdram_slot_timer.sv
sdram_port_arbiter.sv
sdram_cmd_issuer.sv
sdram_ctrl.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sdram_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_sdram_ctrl.sv ====
`timescale 1ns/1ps

module tb_sdram_ctrl
	import sdram_pkg::*;
();

	localparam int init_cycles = 36 * 8;   // 35 wait slots plus one
	localparam int test_slots  = 44;
	localparam int cycle_limit = init_cycles + test_slots * 8 * 2;
	localparam logic [11:0] mode_word = 12'h221; // bl2, sequential, cl2, single writes

	logic        clk, init_n, clkref;
	logic        port1_req, port1_ack, port1_we;
	logic [22:1] port1_a;
	logic [1:0]  port1_ds;
	logic [15:0] port1_d;
	logic [31:0] port1_q, cpu1_q;
	logic [22:2] cpu1_addr;
	logic        cpu1_oe;
	logic        ncs, nras, ncas, nwe, dqml, dqmh, dq_oe;
	logic [11:0] sd_a;
	logic [1:0]  sd_ba;
	logic [15:0] dq_in, dq_out;
	sdram_cmd_e  pin_cmd;

	int          cyc = 0;        // clocks since reset release
	int          seed = 32'h1219;
	int          errors = 0;
	int          checks = 0;
	int          refresh_hits = 0;
	logic        idle_check, cpu1_only;
	logic [15:0] ref_mem [int];  // reference words by word address

	assign pin_cmd = sdram_cmd_e'({ncs, nras, ncas, nwe});

	sdram_ctrl #(.mhz(1)) dut0 (
		.clk(clk), .init_n(init_n), .clkref(clkref),
		.port1_req(port1_req), .port1_ack(port1_ack), .port1_we(port1_we),
		.port1_a(port1_a), .port1_ds(port1_ds), .port1_d(port1_d), .port1_q(port1_q),
		.cpu1_addr(cpu1_addr), .cpu1_q(cpu1_q), .cpu1_oe(cpu1_oe),
		.sdram_ncs(ncs), .sdram_nras(nras), .sdram_ncas(ncas), .sdram_nwe(nwe),
		.sdram_a(sd_a), .sdram_ba(sd_ba), .sdram_dqml(dqml), .sdram_dqmh(dqmh),
		.dq_in(dq_in), .dq_out(dq_out), .dq_oe(dq_oe)
	);

	tb_sdram_model model0 (
		.clk(clk), .init_n(init_n), .ncs(ncs), .nras(nras), .ncas(ncas), .nwe(nwe),
		.a(sd_a), .ba(sd_ba), .dqml(dqml), .dqmh(dqmh),
		.dq_w(dq_out), .dq_w_oe(dq_oe), .dq_r(dq_in)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// cycle count, timeout, clkref
	// ------------------------------
	always @(posedge clk) begin
		if (init_n) begin
			cyc <= cyc + 1;
			if (cyc >= cycle_limit) begin
				$display("run timed out after %0d cycles", cycle_limit);
				$display("Testbench failed");
				$finish;
			end
		end
	end

	// pulse lands on the edge that wraps phase 7 anyway
	always @(negedge clk)
		clkref <= init_n && (((cyc + 1) % 8) == 0);

	// ------------------------------
	// concurrent checks
	// ------------------------------
	assert property (@(posedge clk) disable iff (!init_n)
		(cyc < 35 * 8) |-> ((pin_cmd != active) && (pin_cmd != read) && (pin_cmd != write)))
		else begin
			$display("access command %b issued during the power-up wait at %0t", pin_cmd, $time);
			errors++;
		end

	assert property (@(posedge clk) (idle_check && ((cyc % 8) == 1)) |-> (pin_cmd == auto_refresh))
		else begin
			$display("MISMATCH t=%0t sdram_cmd expected %b got %b", $time, auto_refresh, pin_cmd);
			errors++;
		end

	assert property (@(posedge clk) cpu1_only |-> $stable(port1_ack))
		else begin
			$display("MISMATCH t=%0t port1_ack expected stable got %b", $time, port1_ack);
			errors++;
		end

	always @(posedge clk)
		if (idle_check && ((cyc % 8) == 1) && (pin_cmd == auto_refresh))
			refresh_hits++; // phase-0 command on the pins

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	function automatic logic [15:0] ref_word(input logic [22:1] a);
		logic [21:0] k;
		k = a;
		if (ref_mem.exists(int'(k)))
			return ref_mem[int'(k)];
		return k[15:0] ^ k[21:6]; // model fill pattern
	endfunction

	function automatic logic [15:0] mask_merge(input logic [15:0] old, input logic [15:0] d,
		input logic [1:0] ds);
		logic [15:0] w;
		w = old;
		if (ds[0]) w[7:0] = d[7:0];
		if (ds[1]) w[15:8] = d[15:8];
		return w;
	endfunction

	function automatic logic [22:1] even_addr();
		logic [22:1] a;
		a = 22'($random(seed));
		a[1] = 1'b0; // first word of a pair
		return a;
	endfunction

	// toggle req, wait for the matching ack
	task automatic handshake();
		int lat;
		port1_req = ~port1_req;
		lat = 0;
		while ((port1_ack !== port1_req) && (lat < 40)) begin
			@(negedge clk);
			lat++;
		end
		checks++;
		if (port1_ack !== port1_req) begin
			$display("port1 ack never arrived for the request at %0t", $time);
			errors++;
		end else begin
			assert (lat <= 17) else begin
				$display("port1 ack took %0d cycles, more than 17", lat);
				errors++;
			end
		end
	endtask

	task automatic write_word(input logic [22:1] a, input logic [15:0] d, input logic [1:0] ds);
		port1_we = 1'b1;
		port1_a  = a;
		port1_d  = d;
		port1_ds = ds;
		handshake();
		ref_mem[int'(22'(a))] = mask_merge(ref_word(a), d, ds);
		port1_we = 1'b0;
	endtask

	task automatic read_pair(input logic [22:1] a);
		port1_we = 1'b0;
		port1_a  = a;
		port1_ds = 2'b11;
		handshake();
		check_val("port1_q", {ref_word(a + 22'd1), ref_word(a)}, port1_q);
	endtask

	task automatic report(input string name, input int e0);
		$display("test %s: %0d errors", name, errors - e0);
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		logic [22:1] a;
		logic [22:1] addrs [0:2];
		int e0;
		int n;
		init_n     = 1'b0;
		clkref     = 1'b0;
		port1_req  = 1'b0;
		port1_we   = 1'b0;
		port1_a    = '0;
		port1_ds   = 2'b11;
		port1_d    = 16'd0;
		cpu1_addr  = '0;
		cpu1_oe    = 1'b0;
		idle_check = 1'b0;
		cpu1_only  = 1'b0;
		repeat (4) @(negedge clk);

		// idle pins in reset and the power-up command order
		e0 = errors;
		check_val("sdram_cmd", 32'(nop), 32'(pin_cmd));
		check_val("dqm", 32'd3, {30'd0, dqmh, dqml});
		check_val("dq_oe", 32'd0, 32'(dq_oe));
		check_val("port1_ack", 32'd0, 32'(port1_ack));
		cpu1_oe = 1'b1; // a pending cpu1 read has to wait for the end of power-up
		init_n  = 1'b1;
		n = 0;
		while ((model0.log_n < 10) && (n < 400)) begin
			@(negedge clk);
			n++;
		end
		check_val("log_cmd[0]", 32'(precharge), 32'(model0.log_cmd[0]));
		check_val("log_a[0][10]", 32'd1, 32'(model0.log_a[0][10]));
		for (int i = 1; i <= 8; i++)
			check_val("log_cmd refresh", 32'(auto_refresh), 32'(model0.log_cmd[i]));
		check_val("log_cmd[9]", 32'(load_mode), 32'(model0.log_cmd[9]));
		check_val("log_a[9]", 32'(mode_word), 32'(model0.log_a[9]));
		while (cyc < init_cycles) @(negedge clk);
		cpu1_oe = 1'b0;
		report("init_sequence", e0);

		// full word writes, then pair reads
		e0 = errors;
		for (int i = 0; i < 3; i++) begin
			addrs[i] = even_addr();
			write_word(addrs[i], 16'($random(seed)), 2'b11);
			write_word(addrs[i] + 22'd1, 16'($random(seed)), 2'b11);
		end
		for (int i = 0; i < 3; i++)
			read_pair(addrs[i]);
		report("write_read", e0);

		// single byte writes
		e0 = errors;
		write_word(addrs[0], 16'($random(seed)), 2'b01);
		write_word(addrs[0] + 22'd1, 16'($random(seed)), 2'b10);
		read_pair(addrs[0]);
		report("byte_masks", e0);

		// cpu1 alone
		e0 = errors;
		a = even_addr();
		write_word(a, 16'($random(seed)), 2'b11);
		write_word(a + 22'd1, 16'($random(seed)), 2'b11);
		cpu1_addr = a[22:2];
		cpu1_oe   = 1'b1;
		@(negedge clk); // last write ack has settled
		cpu1_only = 1'b1;
		repeat (23) @(negedge clk); // two full slots
		cpu1_only = 1'b0;
		check_val("cpu1_q", {ref_word(a + 22'd1), ref_word(a)}, cpu1_q);
		report("cpu1_read", e0);

		// port1 ahead of a busy cpu1, then idle slots refresh
		e0 = errors;
		read_pair(addrs[1]);
		repeat (16) @(negedge clk);
		check_val("cpu1_q", {ref_word(a + 22'd1), ref_word(a)}, cpu1_q);
		cpu1_oe = 1'b0;
		while ((cyc % 8) != 2) @(negedge clk);
		n = refresh_hits;
		idle_check = 1'b1;
		repeat (24) @(negedge clk);
		idle_check = 1'b0;
		check_val("refresh slots", 32'd3, 32'(refresh_hits - n));
		report("priority_refresh", e0);

		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tb_sdram_model.sv ====
`timescale 1ns/1ps

module tb_sdram_model
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        init_n,
	input  logic        ncs,
	input  logic        nras,
	input  logic        ncas,
	input  logic        nwe,
	input  logic [11:0] a,
	input  logic [1:0]  ba,
	input  logic        dqml,
	input  logic        dqmh,
	input  logic [15:0] dq_w,    // controller write data
	input  logic        dq_w_oe,
	output logic [15:0] dq_r     // read data back to the controller
);

	sdram_cmd_e  cmd;
	logic [11:0] row_open [0:3]; // open row per bank
	logic [15:0] mem [int];      // word storage, key is {bank, row, col}
	sdram_cmd_e  log_cmd [0:63]; // received commands, nop left out
	logic [11:0] log_a [0:63];
	int          log_n;
	logic        rd1;            // cas latency pipe
	logic        rd2;
	logic [21:0] rd_key;

	assign cmd = sdram_cmd_e'({ncs, nras, ncas, nwe});

	// unwritten words read back a pattern of the full address
	function automatic logic [15:0] fill(input logic [21:0] k);
		return k[15:0] ^ k[21:6];
	endfunction

	function automatic logic [15:0] word_at(input logic [21:0] k);
		if (mem.exists(int'(k)))
			return mem[int'(k)];
		return fill(k);
	endfunction

	// ------------------------------
	// command decode
	// ------------------------------
	always @(posedge clk or negedge init_n) begin : decode
		logic [21:0] k;
		logic [15:0] w;
		if (!init_n) begin
			rd1   <= 1'b0;
			rd2   <= 1'b0;
			dq_r  <= 16'd0;
			log_n = 0;
			for (int i = 0; i < 4; i++)
				row_open[i] <= 12'd0;
		end else begin
			k = {ba, row_open[ba], a[7:0]};
			if ((cmd != nop) && (cmd != inhibit) && (log_n < 64)) begin
				log_cmd[log_n] = cmd; // keep for the init check
				log_a[log_n]   = a;
				log_n++;
			end
			if (cmd == active)
				row_open[ba] <= a;
			if ((cmd == write) && dq_w_oe) begin
				w = word_at(k);
				if (!dqml) w[7:0] = dq_w[7:0];   // low byte enabled
				if (!dqmh) w[15:8] = dq_w[15:8];
				mem[int'(k)] = w;
			end
			// cl2, first word on the pins two clocks after the read
			rd1 <= (cmd == read);
			if (cmd == read)
				rd_key <= k;
			rd2 <= rd1;
			if (rd1)
				dq_r <= word_at(rd_key);
			else if (rd2)
				dq_r <= word_at({rd_key[21:1], ~rd_key[0]}); // burst wraps in pair
		end
	end

endmodule

// ==== sdram_ctrl.sv ====
`timescale 1ns/1ps

module sdram_ctrl
	import sdram_pkg::*;
#(
	parameter int mhz = 80 // sdram clock in mhz
) (
	input  logic        clk,
	input  logic        init_n,     // held low after configuration
	input  logic        clkref,
	// port1, toggle handshake
	input  logic        port1_req,
	output logic        port1_ack,
	input  logic        port1_we,
	input  logic [22:1] port1_a,
	input  logic [1:0]  port1_ds,
	input  logic [15:0] port1_d,
	output logic [31:0] port1_q,
	// cpu1, read only
	input  logic [22:2] cpu1_addr,
	output logic [31:0] cpu1_q,
	input  logic        cpu1_oe,
	// sdram pins, dq split for the board wrapper
	output logic        sdram_ncs,
	output logic        sdram_nras,
	output logic        sdram_ncas,
	output logic        sdram_nwe,
	output logic [11:0] sdram_a,
	output logic [1:0]  sdram_ba,
	output logic        sdram_dqml,
	output logic        sdram_dqmh,
	input  logic [15:0] dq_in,
	output logic [15:0] dq_out,
	output logic        dq_oe
);

	// ------------------------------
	// internal nets
	// ------------------------------
	logic [2:0]  phase;
	logic [10:0] wait_count;
	logic        init_busy;
	logic        next_valid;
	logic [22:1] next_addr;
	port_sel_e   sel_port;
	logic [22:1] lat_addr;
	logic [15:0] lat_din;
	logic [1:0]  lat_ds;
	logic        lat_rd;
	logic        lat_wr;
	sdram_cmd_e  sdram_cmd;

	// strobe pins straight from the command encoding
	assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = sdram_cmd;

	sdram_slot_timer #(.mhz(mhz)) timer0 (
		.clk(clk), .init_n(init_n), .clkref(clkref),
		.phase(phase), .wait_count(wait_count), .init_busy(init_busy)
	);

	sdram_port_arbiter arb0 (
		.clk(clk), .init_n(init_n), .phase(phase), .init_busy(init_busy),
		.port1_req(port1_req), .port1_we(port1_we), .port1_a(port1_a),
		.port1_ds(port1_ds), .port1_d(port1_d),
		.cpu1_addr(cpu1_addr), .cpu1_oe(cpu1_oe),
		.next_valid(next_valid), .next_addr(next_addr), .sel_port(sel_port),
		.lat_addr(lat_addr), .lat_din(lat_din), .lat_ds(lat_ds),
		.lat_rd(lat_rd), .lat_wr(lat_wr)
	);

	sdram_cmd_issuer issuer0 (
		.clk(clk), .init_n(init_n), .phase(phase), .wait_count(wait_count),
		.init_busy(init_busy), .next_valid(next_valid), .next_addr(next_addr),
		.sel_port(sel_port), .lat_addr(lat_addr), .lat_din(lat_din),
		.lat_ds(lat_ds), .lat_rd(lat_rd), .lat_wr(lat_wr),
		.port1_req(port1_req), .dq_in(dq_in),
		.sdram_cmd(sdram_cmd), .sdram_a(sdram_a), .sdram_ba(sdram_ba),
		.sdram_dqml(sdram_dqml), .sdram_dqmh(sdram_dqmh),
		.dq_out(dq_out), .dq_oe(dq_oe),
		.port1_ack(port1_ack), .port1_q(port1_q), .cpu1_q(cpu1_q)
	);

endmodule

// ==== sdram_cmd_issuer.sv ====
`timescale 1ns/1ps

module sdram_cmd_issuer
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        init_n,
	input  logic [2:0]  phase,
	input  logic [10:0] wait_count,
	input  logic        init_busy,
	input  logic        next_valid,
	input  logic [22:1] next_addr,
	input  port_sel_e   sel_port,
	input  logic [22:1] lat_addr,
	input  logic [15:0] lat_din,
	input  logic [1:0]  lat_ds,
	input  logic        lat_rd,
	input  logic        lat_wr,
	input  logic        port1_req,
	input  logic [15:0] dq_in,      // from the pad input register side
	output sdram_cmd_e  sdram_cmd,
	output logic [11:0] sdram_a,
	output logic [1:0]  sdram_ba,
	output logic        sdram_dqml,
	output logic        sdram_dqmh,
	output logic [15:0] dq_out,
	output logic        dq_oe,      // high while driving write data
	output logic        port1_ack,
	output logic [31:0] port1_q,
	output logic [31:0] cpu1_q
);

	logic [15:0] sd_din; // dq registered every clock
	logic        at_ras;
	logic        at_cas;
	logic        read_slot;

	assign at_ras    = (phase == phase_ras0);
	assign at_cas    = (phase == phase_cas0) && (lat_rd || lat_wr);
	assign read_slot = lat_rd && (sel_port != port_none);

	// ------------------------------
	// command, address and mask lines
	// ------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			sdram_cmd                <= nop;
			sdram_a                  <= 12'd0;
			sdram_ba                 <= 2'b00;
			{sdram_dqmh, sdram_dqml} <= 2'b11;
			dq_oe                    <= 1'b0;
			port1_ack                <= 1'b0;
		end else begin
			// defaults, one-clock commands
			sdram_cmd                <= nop;
			{sdram_dqmh, sdram_dqml} <= 2'b11;
			dq_oe                    <= 1'b0;

			if (init_busy) begin
				// init commands sit in the last ten slots of the wait
				if (at_ras) begin
					if (wait_count == 11'd10) begin
						sdram_cmd   <= precharge;
						sdram_a[10] <= 1'b1; // all banks
					end
					if ((wait_count <= 11'd9) && (wait_count > 11'd1)) begin
						sdram_cmd <= auto_refresh; // eight of them
					end
					if (wait_count == 11'd1) begin
						sdram_cmd <= load_mode;
						sdram_a   <= sdram_mode;
						sdram_ba  <= 2'b00;
					end
				end
			end else begin
				// row open, or refresh on an idle slot
				if (at_ras) begin
					if (next_valid) begin
						sdram_cmd <= active;
						sdram_a   <= next_addr[20:9];  // row
						sdram_ba  <= next_addr[22:21];
					end else begin
						sdram_cmd <= auto_refresh;
					end
				end

				// column access, a10 set for auto precharge
				if (at_cas) begin
					sdram_cmd                <= lat_wr ? write : read;
					sdram_a                  <= {4'b0100, lat_addr[8:1]};
					sdram_ba                 <= lat_addr[22:21];
					{sdram_dqmh, sdram_dqml} <= ~lat_ds;
					if (lat_wr) begin
						dq_oe     <= 1'b1;
						port1_ack <= port1_req; // write done once issued
					end
				end

				// keep the mask open for the second burst word
				if ((phase == phase_ds1) && lat_rd) begin
					{sdram_dqmh, sdram_dqml} <= ~lat_ds;
				end

				if ((phase == phase_read1) && lat_rd && (sel_port == port_req)) begin
					port1_ack <= port1_req; // both words in port1_q now
				end
			end
		end
	end

	// ------------------------------
	// data path
	// ------------------------------
	always_ff @(posedge clk) begin
		sd_din <= dq_in; // ease input timing
		if (at_cas && lat_wr) begin
			dq_out <= lat_din;
		end
		if (!init_busy && read_slot) begin
			if (phase == phase_read0) begin
				case (sel_port)
					port_req:  port1_q[15:0] <= sd_din; // first word
					port_cpu1: cpu1_q[15:0]  <= sd_din;
					default: ;
				endcase
			end
			if (phase == phase_read1) begin
				case (sel_port)
					port_req:  port1_q[31:16] <= sd_din; // second word
					port_cpu1: cpu1_q[31:16]  <= sd_din;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== sdram_port_arbiter.sv ====
`timescale 1ns/1ps

module sdram_port_arbiter
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        init_n,
	input  logic [2:0]  phase,
	input  logic        init_busy,
	input  logic        port1_req,  // toggles for a new request
	input  logic        port1_we,
	input  logic [22:1] port1_a,
	input  logic [1:0]  port1_ds,
	input  logic [15:0] port1_d,
	input  logic [22:2] cpu1_addr,  // 32-bit aligned
	input  logic        cpu1_oe,
	output logic        next_valid, // a port wants this slot
	output logic [22:1] next_addr,  // row and bank for the activate
	output port_sel_e   sel_port,   // owner of the running slot
	output logic [22:1] lat_addr,
	output logic [15:0] lat_din,
	output logic [1:0]  lat_ds,
	output logic        lat_rd,
	output logic        lat_wr
);

	port_sel_e next_port;
	logic      port1_state; // last granted value of port1_req
	logic      slot_grant;  // arbitration point

	assign slot_grant = (phase == phase_ras0) && !init_busy;
	assign next_valid = (next_port != port_none);

	// ------------------------------
	// pick the next owner, port1 first
	// ------------------------------
	always_comb begin
		next_port = port_none;
		next_addr = lat_addr; // idle keeps the old address
		if (port1_req != port1_state) begin
			next_port = port_req; // toggle seen
			next_addr = port1_a;
		end else if (cpu1_oe) begin
			next_port = port_cpu1;
			next_addr = {cpu1_addr, 1'b0}; // low word of the pair
		end
	end

	// slot ownership and direction
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			sel_port    <= port_none;
			lat_rd      <= 1'b0;
			lat_wr      <= 1'b0;
			port1_state <= 1'b0;
		end else if (slot_grant) begin
			sel_port <= next_port;
			lat_rd   <= 1'b0;
			lat_wr   <= 1'b0;
			case (next_port)
				port_req: begin
					lat_rd      <= ~port1_we;
					lat_wr      <= port1_we;
					port1_state <= port1_req; // request taken
				end
				port_cpu1: lat_rd <= 1'b1; // cpu1 only reads
				default: ;
			endcase
		end
	end

	// access payload
	always_ff @(posedge clk) begin
		if (slot_grant) begin
			lat_addr <= next_addr;
			if (next_port == port_req) begin
				lat_ds  <= port1_ds;
				lat_din <= port1_d;
			end else if (next_port == port_cpu1) begin
				lat_ds <= 2'b11; // full word
			end
		end
	end

endmodule

// ==== sdram_slot_timer.sv ====
`timescale 1ns/1ps

module sdram_slot_timer
	import sdram_pkg::*;
#(
	parameter int mhz = 80 // clock rate, scales the power-up wait
) (
	input  logic        clk,
	input  logic        init_n,
	input  logic        clkref,     // slot alignment from the core clock enable
	output logic [2:0]  phase,      // position inside the slot
	output logic [10:0] wait_count, // power-up slots left
	output logic        init_busy   // high while the power-up sequence runs
);

	// power-up wait in slots, the last ten carry the init commands
	localparam logic [10:0] rst_count = 11'(10 + 25 * mhz);

	logic clkref_d;   // previous clkref for edge detect
	logic clkref_rise;

	assign clkref_rise = clkref & ~clkref_d;

	// ------------------------------
	// slot phase counter
	// ------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			clkref_d <= 1'b0;
			phase    <= phase_ras0;
		end else begin
			clkref_d <= clkref;
			if (clkref_rise) begin
				phase <= phase_ras0; // realign to the core
			end else if (phase == phase_last) begin
				phase <= phase_ras0; // wrap
			end else begin
				phase <= phase + 3'd1;
			end
		end
	end

	// ------------------------------
	// power-up wait
	// ------------------------------
	// counts once per slot, init_busy follows one clock behind the count
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			wait_count <= rst_count;
			init_busy  <= 1'b1;
		end else begin
			if ((phase == phase_last) && (wait_count != 11'd0)) begin
				wait_count <= wait_count - 11'd1; // one step per slot
			end
			init_busy <= (wait_count != 11'd0);
		end
	end

endmodule

// ==== sdram_pkg.sv ====
package sdram_pkg;

	// ------------------------------
	// sdram commands {ncs, nras, ncas, nwe}
	// ------------------------------
	typedef enum logic [3:0] {
		inhibit         = 4'b1111, // chip deselected
		nop             = 4'b0111,
		active          = 4'b0011, // open row
		read            = 4'b0101,
		write           = 4'b0100,
		burst_terminate = 4'b0110,
		precharge       = 4'b0010, // a10 high closes all banks
		auto_refresh    = 4'b0001,
		load_mode       = 4'b0000  // mode word on the address bus
	} sdram_cmd_e;

	// which client owns the current slot
	typedef enum logic [1:0] {
		port_none = 2'd0, // idle slot, used for refresh
		port_cpu1 = 2'd1,
		port_req  = 2'd2  // toggle handshake port
	} port_sel_e;

	// ------------------------------
	// mode register fields
	// ------------------------------
	localparam logic [2:0] burst_length   = 3'b001; // two words
	localparam logic       access_type    = 1'b0;   // sequential
	localparam logic [2:0] cas_latency    = 3'd2;
	localparam logic [1:0] op_mode        = 2'b00;  // standard operation
	localparam logic       no_write_burst = 1'b1;   // writes are single words

	localparam logic [11:0] sdram_mode = {2'b00, no_write_burst, op_mode,
		cas_latency, access_type, burst_length};

	// ------------------------------
	// slot phases, eight clocks per slot
	// ------------------------------
	localparam logic [2:0] rascas_delay = 3'd2; // trcd of 20ns below 100mhz

	localparam logic [2:0] phase_ras0  = 3'd0;                        // activate or refresh
	localparam logic [2:0] phase_cas0  = phase_ras0 + rascas_delay;   // read or write
	localparam logic [2:0] phase_ds1   = phase_cas0 + 3'd1;           // second word mask
	localparam logic [2:0] phase_read0 = phase_cas0 + cas_latency + 3'd2; // low word in
	localparam logic [2:0] phase_read1 = phase_cas0 + cas_latency + 3'd3; // high word in
	localparam logic [2:0] phase_last  = 3'd7;

endpackage
